//--- include/ospfb_config.svh
`ifndef OSPFB_CONFIG_SVH
`define OSPFB_CONFIG_SVH

// sample word, loop value and partial sum width
`define OSPFB_WIDTH 16

// signed coefficient width, rom entries must fit
`define OSPFB_COEFF_WID 8

// polyphase branch count, also the phase timer period
`define OSPFB_FFT_LEN 8

// accepted samples per period (oversampling ratio FFT_LEN/DEC_FAC)
`define OSPFB_DEC_FAC 6

// decimation phase loaded at reset
// picks which branch sees the first sample
`define OSPFB_SRT_PHA 5

// taps per polyphase branch = number of pe in the chain
`define OSPFB_PTAPS 4

`endif // OSPFB_CONFIG_SVH

//--- logic/ospfb_pkg.sv
`include "ospfb_config.svh"

package ospfb_pkg;

  // signed sample, also used for the loop values and the partial sums
  typedef logic signed [`OSPFB_WIDTH-1:0] sample_t;

  // signed filter coefficient held in each pe rom
  typedef logic signed [`OSPFB_COEFF_WID-1:0] coeff_t;

  // unsigned count over one period
  // shared by the phase timer and the coefficient address
  typedef logic [$clog2(`OSPFB_FFT_LEN)-1:0] phase_t;

endpackage

//--- logic/wb_pkg.sv
`include "ospfb_config.svh"

package wb_pkg;

  // raw data word on the wishbone slave port, one sample per write
  // carries no sign of its own, the intake reinterprets it
  typedef logic [`OSPFB_WIDTH-1:0] wb_dat_t;

endpackage

//--- logic/delay_buf.sv
module delay_buf #(
  parameter int DEPTH = 8,  // delay in enabled cycles, at least one
  parameter int WIDTH = 16
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             en,    // shifts only when high
  input  logic [WIDTH-1:0] din,
  output logic [WIDTH-1:0] dout
);

  logic [WIDTH-1:0] line [DEPTH];  // line[0] is the newest entry

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < DEPTH; i++) begin
        line[i] <= '0;  // lines come up empty so nothing valid leaks out
      end
    end else if (en) begin
      line[0] <= din;
      for (int i = 1; i < DEPTH; i++) begin
        line[i] <= line[i-1];
      end
    end
  end

  // oldest entry, written DEPTH enabled cycles ago
  assign dout = line[DEPTH-1];

endmodule

//--- logic/sample_intake.sv
`include "ospfb_config.svh"

module sample_intake (
  input  logic               clk,
  input  logic               rst,
  input  logic               en,      // global freeze when low
  input  logic               wb_cyc,
  input  logic               wb_stb,
  input  logic               wb_we,
  input  wb_pkg::wb_dat_t    wb_dat,  // sample as written by the master
  output logic               wb_ack,  // combinational classic ack
  output logic               vin,     // sample strobe into the first pe
  output ospfb_pkg::sample_t din
);

  import ospfb_pkg::*;

  localparam phase_t SRT_PHA  = phase_t'(`OSPFB_SRT_PHA);
  localparam phase_t LAST_PHA = phase_t'(`OSPFB_FFT_LEN - 1);

  phase_t phase;   // decimation phase, counts 0..FFT_LEN-1
  logic   window;  // accept slot
  logic   req;     // write cycle in progress

  // phase timer, frozen along with the rest of the datapath
  always_ff @(posedge clk) begin
    if (rst) begin
      phase <= SRT_PHA;
    end else if (en) begin
      if (phase == LAST_PHA) begin
        phase <= '0;  // period wrap
      end else begin
        phase <= phase + 1'b1;
      end
    end
  end

  // only the first DEC_FAC phases take a new sample
  // the rest of the period is feedback, the pe chain reuses loop data
  assign window = (int'(phase) < `OSPFB_DEC_FAC);

  assign req = wb_cyc & wb_stb & wb_we;

  // master holds stb and data until this goes high
  // no ack while the slave is in reset
  assign wb_ack = req & en & window & ~rst;

  assign vin = wb_ack;                         // one sample per acked write
  assign din = vin ? sample_t'(wb_dat) : '0;   // zero outside a write, pe ignores it

endmodule

//--- logic/pe.sv
`include "ospfb_config.svh"

module pe #(
  parameter int TAP = 0  // position in the chain, selects the rom contents
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               en,
  input  logic               vin,   // fresh sample on din
  input  ospfb_pkg::sample_t din,
  input  ospfb_pkg::sample_t sin,   // partial sum from the previous element
  output logic               vout,
  output ospfb_pkg::sample_t dout,  // sample stream for the next element
  output ospfb_pkg::sample_t sout   // partial sum for the next element
);

  import ospfb_pkg::*;

  localparam int FFT_LEN    = `OSPFB_FFT_LEN;
  localparam int LOOP_DEPTH = `OSPFB_FFT_LEN - `OSPFB_DEC_FAC;  // feedback slots per period
  localparam phase_t LAST_ADDR = phase_t'(FFT_LEN - 1);

  typedef coeff_t rom_t [FFT_LEN];

  // entry j of element k holds k*FFT_LEN + j + 1
  function automatic rom_t rom_init();
    rom_t r;
    for (int j = 0; j < FFT_LEN; j++) begin
      r[j] = coeff_t'(TAP * FFT_LEN + j + 1);
    end
    return r;
  endfunction

  localparam rom_t ROM = rom_init();  // fixed at elaboration

  phase_t  addr;      // coefficient address, counts down
  coeff_t  h;         // current tap value
  sample_t a;         // fresh or recirculated sample
  sample_t mac;       // sin + a*h, wraps at WIDTH bits
  sample_t loop_out;

  // branches are visited in reverse order
  always_ff @(posedge clk) begin
    if (rst) begin
      addr <= '0;
    end else if (en) begin
      if (addr == '0) begin
        addr <= LAST_ADDR;
      end else begin
        addr <= addr - 1'b1;
      end
    end
  end

  assign h = ROM[addr];

  // feedback phase reuses what went around the loop
  assign a = vin ? din : loop_out;

  // 16 bit context, product is truncated before the add
  assign mac = sin + a * h;

  delay_buf #(
    .DEPTH(LOOP_DEPTH),
    .WIDTH(`OSPFB_WIDTH)
  ) loop_buf (
    .clk (clk),
    .rst (rst),
    .en  (en),
    .din (a),
    .dout(loop_out)
  );

  // two periods so the next element sees the samples one tap later
  delay_buf #(
    .DEPTH(2 * FFT_LEN),
    .WIDTH(`OSPFB_WIDTH)
  ) data_buf (
    .clk (clk),
    .rst (rst),
    .en  (en),
    .din (loop_out),
    .dout(dout)
  );

  delay_buf #(
    .DEPTH(FFT_LEN),
    .WIDTH(`OSPFB_WIDTH)
  ) sum_buf (
    .clk (clk),
    .rst (rst),
    .en  (en),
    .din (mac),
    .dout(sout)
  );

  delay_buf #(
    .DEPTH(FFT_LEN),
    .WIDTH(1)  // valid rides alongside the sum
  ) valid_buf (
    .clk (clk),
    .rst (rst),
    .en  (en),
    .din (vin),
    .dout(vout)
  );

endmodule

//--- logic/ospfb_top.sv
`include "ospfb_config.svh"

module ospfb_top (
  input  logic               clk,
  input  logic               rst,
  input  logic               en,      // freezes every register when low
  input  logic               wb_cyc,
  input  logic               wb_stb,
  input  logic               wb_we,
  input  wb_pkg::wb_dat_t    wb_dat,
  output logic               wb_ack,
  output logic               vout,    // filtered word valid, no ready
  output ospfb_pkg::sample_t sout     // filtered word
);

  import ospfb_pkg::*;

  localparam int PTAPS = `OSPFB_PTAPS;

  // index k feeds pe k, index PTAPS is the chain output
  logic    chain_v [PTAPS+1];
  sample_t chain_s [PTAPS+1];
  sample_t chain_d [PTAPS];   // last dout has no consumer

  sample_intake i_intake (
    .clk   (clk),
    .rst   (rst),
    .en    (en),
    .wb_cyc(wb_cyc),
    .wb_stb(wb_stb),
    .wb_we (wb_we),
    .wb_dat(wb_dat),
    .wb_ack(wb_ack),
    .vin   (chain_v[0]),
    .din   (chain_d[0])
  );

  assign chain_s[0] = '0;  // first tap starts from an empty sum

  for (genvar k = 0; k < PTAPS; k++) begin : g_pe
    if (k < PTAPS - 1) begin : g_mid
      pe #(.TAP(k)) i_pe (
        .clk (clk),
        .rst (rst),
        .en  (en),
        .vin (chain_v[k]),
        .din (chain_d[k]),
        .sin (chain_s[k]),
        .vout(chain_v[k+1]),
        .dout(chain_d[k+1]),
        .sout(chain_s[k+1])
      );
    end else begin : g_last
      pe #(.TAP(k)) i_pe (
        .clk (clk),
        .rst (rst),
        .en  (en),
        .vin (chain_v[k]),
        .din (chain_d[k]),
        .sin (chain_s[k]),
        .vout(chain_v[k+1]),
        .dout(),             // no further tap
        .sout(chain_s[k+1])
      );
    end
  end

  assign vout = chain_v[PTAPS];  // wb_ack delayed PTAPS*FFT_LEN enabled cycles
  assign sout = chain_s[PTAPS];

endmodule

//--- dv/ospfb_ref_model.sv
`include "ospfb_config.svh"

module ospfb_ref_model (
  input  logic               clk,
  input  logic               rst,
  input  logic               en,
  input  logic               wb_cyc,
  input  logic               wb_stb,
  input  logic               wb_we,
  input  wb_pkg::wb_dat_t    wb_dat,
  output logic               ack,
  output logic               vout,
  output ospfb_pkg::sample_t sout,
  output int                 phase   // decimation phase, 0..FFT_LEN-1
);
  timeunit 1ns;
  timeprecision 1ps;

  import ospfb_pkg::*;

  localparam int FL = `OSPFB_FFT_LEN;
  localparam int DF = `OSPFB_DEC_FAC;
  localparam int NT = `OSPFB_PTAPS;
  localparam int LD = FL - DF;  // loop line length

  int      addr;                // one address serves every element, they step together
  sample_t loop_l  [NT][LD];    // index 0 newest, last index is the line output
  sample_t data_l  [NT][2*FL];
  sample_t sum_l   [NT][FL];
  logic    valid_l [NT][FL];

  // accept slot is the first DEC_FAC phases of each period
  assign ack  = wb_cyc && wb_stb && wb_we && en && !rst && (phase < DF);
  assign vout = valid_l[NT-1][FL-1];
  assign sout = sum_l[NT-1][FL-1];

  always @(posedge clk) begin : step
    logic    v;  // valid seen by element k
    sample_t d;  // data seen by element k
    sample_t s;  // partial sum into element k
    sample_t a;
    sample_t m;
    int      h;
    if (rst) begin
      phase   <= `OSPFB_SRT_PHA;
      addr    <= 0;
      loop_l  <= '{default: '0};
      data_l  <= '{default: '0};
      sum_l   <= '{default: '0};
      valid_l <= '{default: 1'b0};
    end else if (en) begin
      v = ack;
      d = ack ? sample_t'(wb_dat) : '0;
      s = '0;                                   // chain starts from an empty sum
      for (int k = 0; k < NT; k++) begin
        h = k * FL + addr + 1;                  // rom entry j of element k
        a = v ? d : loop_l[k][LD-1];            // fresh sample or recirculated one
        m = sample_t'(int'(s) + int'(a) * h);   // keep the low WIDTH bits
        for (int i = 1; i < LD; i++) begin
          loop_l[k][i] <= loop_l[k][i-1];
        end
        for (int i = 1; i < 2*FL; i++) begin
          data_l[k][i] <= data_l[k][i-1];
        end
        for (int i = 1; i < FL; i++) begin
          sum_l[k][i]   <= sum_l[k][i-1];
          valid_l[k][i] <= valid_l[k][i-1];
        end
        loop_l[k][0]  <= a;
        data_l[k][0]  <= loop_l[k][LD-1];       // data line is fed from the loop output
        sum_l[k][0]   <= m;
        valid_l[k][0] <= v;
        v = valid_l[k][FL-1];                   // next element reads this one's tails
        d = data_l[k][2*FL-1];
        s = sum_l[k][FL-1];
      end
      phase <= (phase + 1) % FL;
      addr  <= (addr + FL - 1) % FL;            // counts down with wrap
    end
  end

endmodule

//--- dv/ospfb_tb.sv
`include "ospfb_config.svh"

module ospfb_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import ospfb_pkg::*;
  import wb_pkg::*;

  localparam int DELAY = `OSPFB_PTAPS * `OSPFB_FFT_LEN;  // write to output, in enabled cycles

  // test lengths in clock cycles
  localparam int RST_CYC     = 4;
  localparam int IDLE_CYC    = 8;
  localparam int FULL_CYC    = 96;
  localparam int RAND_CYC    = 320;
  localparam int FREEZE_CYC  = 24;
  localparam int RECOVER_CYC = 200;
  localparam int DRAIN_CYC   = 48;
  localparam int TIMEOUT_CYC = RST_CYC + IDLE_CYC + FULL_CYC + RAND_CYC
                             + FREEZE_CYC + RECOVER_CYC + DRAIN_CYC + 100;  // plus margin

  // check ids, one pass and one fail counter each
  localparam int C_RST_ACK = 0;
  localparam int C_RST_OUT = 1;
  localparam int C_ACK     = 2;
  localparam int C_NO_REQ  = 3;
  localparam int C_VDELAY  = 4;
  localparam int C_VOUT    = 5;
  localparam int C_SOUT    = 6;
  localparam int C_FREEZE  = 7;
  localparam int N_CHK     = 8;

  logic        clk;
  logic        rst;
  logic        en;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  wb_dat_t     wb_dat;
  logic        wb_ack;
  logic        vout;
  sample_t     sout;
  logic        m_ack;
  logic        m_vout;
  sample_t     m_sout;
  int          m_phase;
  logic        live = 1'b0;  // dut has seen at least one reset edge
  logic        written = 1'b0;  // a write was accepted since the last reset
  logic [DELAY-1:0] ack_hist = '0;
  int          cycles = 0;
  int          pass_cnt [N_CHK];
  int          fail_cnt [N_CHK];
  int          prev_fails = 0;

  ospfb_top i_dut (
    .clk(clk), .rst(rst), .en(en),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_dat(wb_dat), .wb_ack(wb_ack),
    .vout(vout), .sout(sout)
  );

  ospfb_ref_model i_ref (
    .clk(clk), .rst(rst), .en(en),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_dat(wb_dat),
    .ack(m_ack), .vout(m_vout), .sout(m_sout), .phase(m_phase)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;  // 40 ns period
  end

  always @(posedge clk) begin
    if (rst) begin
      live     <= 1'b1;
      ack_hist <= '0;
      written  <= 1'b0;
    end else if (en) begin
      ack_hist <= {ack_hist[DELAY-2:0], m_ack};  // model ack, shifted on enabled cycles
      written  <= written | m_ack;
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == TIMEOUT_CYC) begin
      $display("run stopped after %0d cycles, the tests did not finish in time", cycles);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  task automatic log_mismatch(input int id, input string msg);
    fail_cnt[id]++;
    $display("CHECK FAILED at %0t: %s", $time, msg);
  endtask

  function automatic int total_fails();
    int n;
    n = 0;
    foreach (fail_cnt[i]) n += fail_cnt[i];
    return n;
  endfunction

  function automatic int total_passes();
    int n;
    n = 0;
    foreach (pass_cnt[i]) n += pass_cnt[i];
    return n;
  endfunction

  a_rst_ack: assert property (@(posedge clk) rst |-> !wb_ack) pass_cnt[C_RST_ACK]++;
    else log_mismatch(C_RST_ACK, "wb_ack high during reset");
  // outputs stay quiet until the first accepted write has had time to arrive
  a_rst_out: assert property (@(posedge clk) (live && (rst || !written))
                              |-> (!vout && sout == '0))
    pass_cnt[C_RST_OUT]++;
    else log_mismatch(C_RST_OUT, $sformatf("output not quiet after reset, vout %b sout %0d",
                                           $sampled(vout), $sampled(sout)));
  a_ack: assert property (@(posedge clk) wb_ack == m_ack) pass_cnt[C_ACK]++;
    else log_mismatch(C_ACK, $sformatf("wb_ack %b, expected %b at phase %0d",
                                       $sampled(wb_ack), $sampled(m_ack), $sampled(m_phase)));
  a_no_req: assert property (@(posedge clk) (!wb_stb || !en) |-> !wb_ack) pass_cnt[C_NO_REQ]++;
    else log_mismatch(C_NO_REQ, "wb_ack high without stb or with en low");
  a_vdelay: assert property (@(posedge clk) live |-> vout == ack_hist[DELAY-1])
    pass_cnt[C_VDELAY]++;
    else log_mismatch(C_VDELAY, $sformatf("vout %b, ack %0d cycles back was %b",
                                          $sampled(vout), DELAY, $sampled(ack_hist[DELAY-1])));
  a_vout: assert property (@(posedge clk) live |-> vout == m_vout) pass_cnt[C_VOUT]++;
    else log_mismatch(C_VOUT, $sformatf("vout %b, expected %b", $sampled(vout), $sampled(m_vout)));
  a_sout: assert property (@(posedge clk) (live && vout) |-> sout == m_sout) pass_cnt[C_SOUT]++;
    else log_mismatch(C_SOUT, $sformatf("sout %0d, expected %0d", $sampled(sout), $sampled(m_sout)));
  // a cycle with en low must leave outputs and the model phase untouched
  a_freeze: assert property (@(posedge clk) (live && !$past(en) && !$past(rst))
                             |-> ($stable(vout) && $stable(sout) && $stable(m_phase)))
    pass_cnt[C_FREEZE]++;
    else log_mismatch(C_FREEZE, $sformatf("state moved while frozen, vout %b sout %0d",
                                          $sampled(vout), $sampled(sout)));

  // wishbone master, keeps stb and data until acked, then maybe requests again
  task automatic run_master(input int n, input int stb_pct);
    logic req;
    for (int i = 0; i < n; i++) begin
      @(posedge clk);
      if (!wb_stb || wb_ack) begin  // ack seen here is the one taken at this edge
        req = ($urandom % 100) < stb_pct;
        wb_cyc <= (stb_pct > 0);  // cycle stays open, stb alone carries the request
        wb_stb <= req;
        wb_we  <= (stb_pct > 0);
        wb_dat <= req ? wb_dat_t'($urandom) : '0;
      end
    end
  endtask

  task automatic end_test(input string name);
    int now_fails;
    now_fails = total_fails();
    $display("[%0t] test %s finished, %0d failed checks", $time, name, now_fails - prev_fails);
    prev_fails = now_fails;
  endtask

  initial begin : main
    int fails;
    void'($urandom(25432));
    foreach (pass_cnt[i]) begin
      pass_cnt[i] = 0;
      fail_cnt[i] = 0;
    end
    rst    = 1'b1;
    en     = 1'b1;
    wb_cyc = 1'b1;  // write request held through reset, must not be acked
    wb_stb = 1'b1;
    wb_we  = 1'b1;
    wb_dat = '0;
    repeat (RST_CYC) @(posedge clk);
    rst    <= 1'b0;
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
    run_master(IDLE_CYC, 0);
    end_test("reset");
    run_master(FULL_CYC, 100);  // every slot requested
    end_test("full request");
    run_master(RAND_CYC, 60);   // stb withheld in some cycles
    end_test("random stb");
    en <= 1'b0;
    run_master(FREEZE_CYC, 60);
    en <= 1'b1;
    run_master(RECOVER_CYC, 60);
    run_master(DRAIN_CYC, 0);   // let the chain empty out
    end_test("en freeze and recovery");
    fails = total_fails();
    $display("checks passed %0d, failed %0d", total_passes(), fails);
    if (fails == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

//--- ospfb_top.f
+incdir+include
logic/ospfb_pkg.sv
logic/wb_pkg.sv
logic/delay_buf.sv
logic/sample_intake.sv
logic/pe.sv
logic/ospfb_top.sv
dv/ospfb_ref_model.sv
dv/ospfb_tb.sv

//--- Bender.yml
package:
  name: ospfb

export_include_dirs:
  - include

sources:
  - logic/ospfb_pkg.sv
  - logic/wb_pkg.sv
  - logic/delay_buf.sv
  - logic/sample_intake.sv
  - logic/pe.sv
  - logic/ospfb_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/ospfb_ref_model.sv
      - dv/ospfb_tb.sv
